//--- src/loader_pkg.sv
// Download kinds, RAM base addresses, loader widths and mount slot numbers
`default_nettype none

package loader_pkg;

	// Field widths
	localparam int DL_ADDR_W   = 27;
	localparam int RAM_WORD_W  = 32;
	localparam int RAM_BE_W    = 4;
	localparam int HOST_HALF_W = 16;
	localparam int DL_INDEX_W  = 8;
	localparam int DISC_SIZE_W = 30;
	localparam int IMG_SIZE_W  = 64;

	typedef logic [DL_ADDR_W-1:0]   dl_addr_t;
	typedef logic [RAM_WORD_W-1:0]  ram_word_t;
	typedef logic [RAM_BE_W-1:0]    ram_be_t;
	typedef logic [HOST_HALF_W-1:0] host_half_t;
	typedef logic [DL_INDEX_W-1:0]  dl_index_t;
	typedef logic [DISC_SIZE_W-1:0] disc_size_t;
	typedef logic [IMG_SIZE_W-1:0]  img_size_t;

	// Host download indices, disc index is matched on bits 5:0 only
	localparam dl_index_t DL_IDX_BIOS = 8'd0;
	localparam dl_index_t DL_IDX_EXE  = 8'd1;
	localparam dl_index_t DL_IDX_DISC = 8'd2;

	// Where each kind lands in main RAM
	localparam dl_addr_t BIOS_BASE = 27'd2097152;
	localparam dl_addr_t EXE_BASE  = 27'd4194304;

	// Storage mount slots
	localparam int SLOT_DISC   = 1;
	localparam int SLOT_CARD1  = 2;
	localparam int SLOT_CARD2  = 3;
	localparam int MOUNT_SLOTS = 4;

endpackage

`default_nettype wire

//--- src/fb_pkg.sv
// Framebuffer base address, line stride, full-view size and pixel format codes
`default_nettype none

package fb_pkg;

	localparam int FB_DIM_W    = 12;
	localparam int FB_ADDR_W   = 32;
	localparam int FB_FORMAT_W = 5;

	typedef logic [FB_DIM_W-1:0]    fb_dim_t;
	typedef logic [FB_ADDR_W-1:0]   fb_addr_t;
	typedef logic [FB_FORMAT_W-1:0] fb_format_t;

	// VRAM image in DDR3
	localparam fb_addr_t FB_BASE_ADDR       = 32'h3000_0000;
	localparam fb_addr_t FB_STRIDE          = 32'd2048;
	localparam fb_addr_t FB_BYTES_PER_PIXEL = 32'd2;

	// Whole VRAM shown in full view
	localparam fb_dim_t FB_FULL_WIDTH  = 12'd1024;
	localparam fb_dim_t FB_FULL_HEIGHT = 12'd512;

	// Scaler format codes, bits 2:0 give depth
	localparam fb_format_t FB_FMT_RGB16 = 5'b01100;
	localparam fb_format_t FB_FMT_RGB24 = 5'b00101;

endpackage

`default_nettype wire

//--- src/ram_loader.sv
// Download classifier, half-word packer with host wait flag and RAM write port mux
`timescale 1ns/1ns
`default_nettype none

module ram_loader
	import loader_pkg::*;
(
	input  wire        clk_1x,
	input  wire        arst_n,
	input  wire        ioctl_download,
	input  dl_index_t  ioctl_index,
	input  dl_addr_t   ioctl_addr,
	input  wire        ioctl_wr,
	input  host_half_t ioctl_dout,
	output logic       ioctl_wait,
	input  dl_addr_t   core_wr_addr,
	input  ram_word_t  core_wr_data,
	input  ram_be_t    core_wr_be,
	input  wire        core_wr_req,
	output logic       core_wr_ack,
	output dl_addr_t   ram_wr_addr,
	output ram_word_t  ram_wr_data,
	output ram_be_t    ram_wr_be,
	output logic       ram_wr_req,
	input  wire        ram_wr_ack,
	output logic       exe_load,
	output logic       disc_dl_done,
	output disc_size_t disc_dl_size
);

	logic      bios_dl;
	logic      exe_dl;
	logic      disc_dl;
	logic      exe_dl_q;
	logic      disc_dl_q;
	logic      ram_dl_active;
	logic      dl_wr_req;
	dl_addr_t  dl_addr;
	ram_word_t dl_data;

	// ==================================================================
	// Download classification
	// ==================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			bios_dl   <= 1'b0;
			exe_dl    <= 1'b0;
			disc_dl   <= 1'b0;
			exe_dl_q  <= 1'b0;
			disc_dl_q <= 1'b0;
		end else begin
			bios_dl   <= ioctl_download && (ioctl_index == DL_IDX_BIOS);
			exe_dl    <= ioctl_download && (ioctl_index == DL_IDX_EXE);
			disc_dl   <= ioctl_download && (ioctl_index[5:0] == DL_IDX_DISC[5:0]);
			exe_dl_q  <= exe_dl;
			disc_dl_q <= disc_dl;
		end
	end

	// Only firmware and programs go to RAM
	assign ram_dl_active = bios_dl | exe_dl;

	// ==================================================================
	// Half packing and host handshake
	// ==================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_wr_req  <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_wr_req <= 1'b0;
			if (ram_dl_active) begin
				// Word complete, hold host until RAM takes it
				if (ioctl_wr && ioctl_addr[1]) begin
					dl_wr_req  <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (ram_wr_ack) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word assembly
	always_ff @(posedge clk_1x) begin
		if (ram_dl_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				dl_data[15:0] <= ioctl_dout;
				dl_addr       <= ioctl_addr + (bios_dl ? BIOS_BASE : EXE_BASE);
			end else begin
				dl_data[31:16] <= ioctl_dout;
			end
		end
	end

	// ==================================================================
	// End of download events
	// ==================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			exe_load     <= 1'b0;
			disc_dl_done <= 1'b0;
		end else begin
			exe_load     <= exe_dl_q & ~exe_dl;
			disc_dl_done <= disc_dl_q & ~disc_dl;
		end
	end

	// Last host address is the image length
	always_ff @(posedge clk_1x) begin
		if (disc_dl_q && !disc_dl) begin
			disc_dl_size <= disc_size_t'(ioctl_addr);
		end
	end

	// Write port goes to the loader while it runs
	always_comb begin
		if (ram_dl_active) begin
			ram_wr_addr = dl_addr;
			ram_wr_data = dl_data;
			ram_wr_be   = '1;
			ram_wr_req  = dl_wr_req;
			core_wr_ack = 1'b0;
		end else begin
			ram_wr_addr = core_wr_addr;
			ram_wr_data = core_wr_data;
			ram_wr_be   = core_wr_be;
			ram_wr_req  = core_wr_req;
			core_wr_ack = ram_wr_ack;
		end
	end

endmodule

`default_nettype wire

//--- src/media_tracker.sv
// Disc and memory card mount state with memory card load and save triggers
`timescale 1ns/1ns
`default_nettype none

module media_tracker
	import loader_pkg::*;
(
	input  wire                   clk_1x,
	input  wire                   arst_n,
	input  wire [MOUNT_SLOTS-1:0] img_mounted,
	input  img_size_t             img_size,
	input  wire                   disc_dl_done,
	input  disc_size_t            disc_dl_size,
	input  wire                   opt_card_load,
	input  wire                   opt_card_save,
	input  wire                   opt_autosave,
	input  wire                   osd_open,
	output logic                  disc_present,
	output disc_size_t            disc_size,
	output logic                  disc_from_storage,
	output logic                  card1_mounted,
	output logic                  card2_mounted,
	output logic                  card1_load,
	output logic                  card2_load,
	output logic                  card_save
);

	logic img_nonzero;
	logic autosave_req;
	logic card_load_q;
	logic card_save_q;
	logic autosave_q;
	logic load_rise;
	logic save_rise;

	assign img_nonzero  = (img_size != '0);
	assign autosave_req = osd_open & opt_autosave;

	assign load_rise = opt_card_load & ~card_load_q;
	assign save_rise = (opt_card_save & ~card_save_q) | (autosave_req & ~autosave_q);

	// ==================================================================
	// Disc image
	// ==================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			disc_present      <= 1'b0;
			disc_size         <= '0;
			disc_from_storage <= 1'b0;
		end else begin
			if (disc_dl_done) begin
				disc_present      <= 1'b1;
				disc_size         <= disc_dl_size;
				disc_from_storage <= 1'b0;
			end
			// Storage mount has the last word
			if (img_mounted[SLOT_DISC]) begin
				if (img_nonzero) begin
					disc_present      <= 1'b1;
					disc_size         <= img_size[DISC_SIZE_W-1:0];
					disc_from_storage <= 1'b1;
				end else begin
					disc_present <= 1'b0;
				end
			end
		end
	end

	// ==================================================================
	// Memory cards
	// ==================================================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			card1_mounted <= 1'b0;
			card2_mounted <= 1'b0;
		end else begin
			if (img_mounted[SLOT_CARD1]) begin
				card1_mounted <= img_nonzero;
			end
			if (img_mounted[SLOT_CARD2]) begin
				card2_mounted <= img_nonzero;
			end
		end
	end

	// Option edge history
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			card_load_q <= 1'b0;
			card_save_q <= 1'b0;
			autosave_q  <= 1'b0;
		end else begin
			card_load_q <= opt_card_load;
			card_save_q <= opt_card_save;
			autosave_q  <= autosave_req;
		end
	end

	// Load after a fresh mount or on request, save on request or menu open
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			card1_load <= 1'b0;
			card2_load <= 1'b0;
			card_save  <= 1'b0;
		end else begin
			card1_load <= (img_mounted[SLOT_CARD1] & img_nonzero) | load_rise;
			card2_load <= (img_mounted[SLOT_CARD2] & img_nonzero) | load_rise;
			card_save  <= save_rise;
		end
	end

endmodule

`default_nettype wire

//--- src/fb_setup.sv
// Registered framebuffer base, size and pixel format for the scaler
`timescale 1ns/1ns
`default_nettype none

module fb_setup
	import fb_pkg::*;
(
	input  wire        clk_1x,
	input  wire        arst_n,
	input  wire        opt_full_view,
	input  wire        opt_color24,
	input  fb_dim_t    display_width,
	input  fb_dim_t    display_height,
	input  wire [9:0]  display_offset_x,
	input  wire [8:0]  display_offset_y,
	output fb_addr_t   fb_base,
	output fb_dim_t    fb_width,
	output fb_dim_t    fb_height,
	output fb_format_t fb_format
);

	fb_addr_t view_base;

	// Top-left pixel of the displayed area inside VRAM
	assign view_base = FB_BASE_ADDR
		+ fb_addr_t'(display_offset_x) * FB_BYTES_PER_PIXEL
		+ fb_addr_t'(display_offset_y) * FB_STRIDE;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			fb_base   <= '0;
			fb_width  <= '0;
			fb_height <= '0;
			fb_format <= '0;
		end else begin
			if (opt_full_view) begin
				fb_base   <= FB_BASE_ADDR;
				fb_width  <= FB_FULL_WIDTH;
				fb_height <= FB_FULL_HEIGHT;
			end else begin
				fb_base   <= view_base;
				fb_width  <= display_width;
				fb_height <= display_height;
			end
			fb_format <= opt_color24 ? FB_FMT_RGB24 : FB_FMT_RGB16;
		end
	end

endmodule

`default_nettype wire

//--- src/psx_shell_top.sv
// Shell top level joining loader, media tracker and framebuffer setup
`timescale 1ns/1ns
`default_nettype none

module psx_shell_top
	import loader_pkg::*;
	import fb_pkg::*;
(
	input  wire                   clk_1x,
	input  wire                   arst_n,
	// Host downloads
	input  wire                   ioctl_download,
	input  dl_index_t             ioctl_index,
	input  dl_addr_t              ioctl_addr,
	input  wire                   ioctl_wr,
	input  host_half_t            ioctl_dout,
	output logic                  ioctl_wait,
	// Core and RAM write port
	input  dl_addr_t              core_wr_addr,
	input  ram_word_t             core_wr_data,
	input  ram_be_t               core_wr_be,
	input  wire                   core_wr_req,
	output logic                  core_wr_ack,
	output dl_addr_t              ram_wr_addr,
	output ram_word_t             ram_wr_data,
	output ram_be_t               ram_wr_be,
	output logic                  ram_wr_req,
	input  wire                   ram_wr_ack,
	output logic                  exe_load,
	// Storage media
	input  wire [MOUNT_SLOTS-1:0] img_mounted,
	input  img_size_t             img_size,
	input  wire                   opt_card_load,
	input  wire                   opt_card_save,
	input  wire                   opt_autosave,
	input  wire                   osd_open,
	output logic                  disc_present,
	output disc_size_t            disc_size,
	output logic                  disc_from_storage,
	output logic                  card1_mounted,
	output logic                  card2_mounted,
	output logic                  card1_load,
	output logic                  card2_load,
	output logic                  card_save,
	// Framebuffer
	input  wire                   opt_full_view,
	input  wire                   opt_color24,
	input  fb_dim_t               display_width,
	input  fb_dim_t               display_height,
	input  wire [9:0]             display_offset_x,
	input  wire [8:0]             display_offset_y,
	output fb_addr_t              fb_base,
	output fb_dim_t               fb_width,
	output fb_dim_t               fb_height,
	output fb_format_t            fb_format
);

	// Disc download result into the media tracker
	logic       disc_dl_done;
	disc_size_t disc_dl_size;

	ram_loader u_ram_loader (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.core_wr_addr   (core_wr_addr),
		.core_wr_data   (core_wr_data),
		.core_wr_be     (core_wr_be),
		.core_wr_req    (core_wr_req),
		.core_wr_ack    (core_wr_ack),
		.ram_wr_addr    (ram_wr_addr),
		.ram_wr_data    (ram_wr_data),
		.ram_wr_be      (ram_wr_be),
		.ram_wr_req     (ram_wr_req),
		.ram_wr_ack     (ram_wr_ack),
		.exe_load       (exe_load),
		.disc_dl_done   (disc_dl_done),
		.disc_dl_size   (disc_dl_size)
	);

	media_tracker u_media_tracker (
		.clk_1x            (clk_1x),
		.arst_n            (arst_n),
		.img_mounted       (img_mounted),
		.img_size          (img_size),
		.disc_dl_done      (disc_dl_done),
		.disc_dl_size      (disc_dl_size),
		.opt_card_load     (opt_card_load),
		.opt_card_save     (opt_card_save),
		.opt_autosave      (opt_autosave),
		.osd_open          (osd_open),
		.disc_present      (disc_present),
		.disc_size         (disc_size),
		.disc_from_storage (disc_from_storage),
		.card1_mounted     (card1_mounted),
		.card2_mounted     (card2_mounted),
		.card1_load        (card1_load),
		.card2_load        (card2_load),
		.card_save         (card_save)
	);

	fb_setup u_fb_setup (
		.clk_1x           (clk_1x),
		.arst_n           (arst_n),
		.opt_full_view    (opt_full_view),
		.opt_color24      (opt_color24),
		.display_width    (display_width),
		.display_height   (display_height),
		.display_offset_x (display_offset_x),
		.display_offset_y (display_offset_y),
		.fb_base          (fb_base),
		.fb_width         (fb_width),
		.fb_height        (fb_height),
		.fb_format        (fb_format)
	);

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk_1x,
	output logic arst_n
);

	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 8;

	initial begin
		clk_1x = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) clk_1x = ~clk_1x;
		end
	end

	// Release on a falling edge, away from the active edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		@(negedge clk_1x);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/tb_psx_shell.sv
// Testbench top with random stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_psx_shell
	import loader_pkg::*;
	import fb_pkg::*;
();

	// ====================================================================
	// Run length and watchdog
	// ====================================================================
	localparam int DL_WORDS    = 16;
	localparam int DL_RUNS     = 4;
	localparam int CORE_OPS    = 100;
	localparam int DISC_OPS    = 12;
	localparam int RANDOM_OPS  = 300;
	localparam int TOTAL_OPS   = DL_RUNS * DL_WORDS + CORE_OPS + DISC_OPS + RANDOM_OPS;
	localparam int WATCHDOG_NS = TOTAL_OPS * 40 * 8;

	logic                   clk_1x;
	logic                   arst_n;
	logic                   ioctl_download;
	dl_index_t              ioctl_index;
	dl_addr_t               ioctl_addr;
	logic                   ioctl_wr;
	host_half_t             ioctl_dout;
	logic                   ioctl_wait;
	dl_addr_t               core_wr_addr;
	ram_word_t              core_wr_data;
	ram_be_t                core_wr_be;
	logic                   core_wr_req;
	logic                   core_wr_ack;
	dl_addr_t               ram_wr_addr;
	ram_word_t              ram_wr_data;
	ram_be_t                ram_wr_be;
	logic                   ram_wr_req;
	logic                   ram_wr_ack;
	logic                   exe_load;
	logic [MOUNT_SLOTS-1:0] img_mounted;
	img_size_t              img_size;
	logic                   opt_card_load;
	logic                   opt_card_save;
	logic                   opt_autosave;
	logic                   osd_open;
	logic                   disc_present;
	disc_size_t             disc_size;
	logic                   disc_from_storage;
	logic                   card1_mounted;
	logic                   card2_mounted;
	logic                   card1_load;
	logic                   card2_load;
	logic                   card_save;
	logic                   opt_full_view;
	logic                   opt_color24;
	fb_dim_t                display_width;
	fb_dim_t                display_height;
	logic [9:0]             display_offset_x;
	logic [8:0]             display_offset_y;
	fb_addr_t               fb_base;
	fb_dim_t                fb_width;
	fb_dim_t                fb_height;
	fb_format_t             fb_format;

	int unsigned seed_value;

	// Model of media state and option history
	logic       m_disc_present;
	disc_size_t m_disc_size;
	logic       m_disc_from_storage;
	logic       m_card1_mounted;
	logic       m_card2_mounted;
	logic       m_card_load_q;
	logic       m_card_save_q;
	logic       m_autosave_q;

	// Expected pulses and geometry after the next edge
	logic       e_card1_load;
	logic       e_card2_load;
	logic       e_card_save;
	fb_addr_t   e_fb_base;
	fb_dim_t    e_fb_width;
	fb_dim_t    e_fb_height;
	fb_format_t e_fb_format;

	tb_clk_gen u_tb_clk_gen (
		.clk_1x (clk_1x),
		.arst_n (arst_n)
	);

	psx_shell_top u_psx_shell_top (.*);

	// ====================================================================
	// Failure handling and compare tasks
	// ====================================================================
	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_word(input string name, input ram_word_t exp, input ram_word_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input dl_addr_t exp, input dl_addr_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_be(input string name, input ram_be_t exp, input ram_be_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_disc_size(input string name, input disc_size_t exp,
		input disc_size_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_fb_addr(input string name, input fb_addr_t exp, input fb_addr_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_dim(input string name, input fb_dim_t exp, input fb_dim_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_format(input string name, input fb_format_t exp,
		input fb_format_t got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERR %0t ns %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	task automatic init_inputs();
		ioctl_download   = 1'b0;
		ioctl_index      = '0;
		ioctl_addr       = '0;
		ioctl_wr         = 1'b0;
		ioctl_dout       = '0;
		core_wr_addr     = '0;
		core_wr_data     = '0;
		core_wr_be       = '0;
		core_wr_req      = 1'b0;
		ram_wr_ack       = 1'b0;
		img_mounted      = '0;
		img_size         = '0;
		opt_card_load    = 1'b0;
		opt_card_save    = 1'b0;
		opt_autosave     = 1'b0;
		osd_open         = 1'b0;
		opt_full_view    = 1'b0;
		opt_color24      = 1'b0;
		display_width    = '0;
		display_height   = '0;
		display_offset_x = '0;
		display_offset_y = '0;
		m_disc_present      = 1'b0;
		m_disc_size         = '0;
		m_disc_from_storage = 1'b0;
		m_card1_mounted     = 1'b0;
		m_card2_mounted     = 1'b0;
		m_card_load_q       = 1'b0;
		m_card_save_q       = 1'b0;
		m_autosave_q        = 1'b0;
	endtask

	task automatic check_reset_state();
		check_bit("ram_wr_req", 1'b0, ram_wr_req);
		check_bit("ioctl_wait", 1'b0, ioctl_wait);
		check_bit("exe_load", 1'b0, exe_load);
		check_bit("card1_load", 1'b0, card1_load);
		check_bit("card2_load", 1'b0, card2_load);
		check_bit("card_save", 1'b0, card_save);
		check_bit("disc_present", 1'b0, disc_present);
		check_bit("disc_from_storage", 1'b0, disc_from_storage);
		check_bit("card1_mounted", 1'b0, card1_mounted);
		check_bit("card2_mounted", 1'b0, card2_mounted);
	endtask

	// No download running, so the core owns the RAM write port
	task automatic run_core_passthrough();
		int i;
		for (i = 0; i < CORE_OPS; i++) begin
			@(negedge clk_1x);
			core_wr_addr = dl_addr_t'($urandom);
			core_wr_data = $urandom;
			core_wr_be   = ram_be_t'($urandom);
			core_wr_req  = $urandom_range(0, 1);
			ram_wr_ack   = $urandom_range(0, 1);
			#1;
			check_addr("ram_wr_addr", core_wr_addr, ram_wr_addr);
			check_word("ram_wr_data", core_wr_data, ram_wr_data);
			check_be("ram_wr_be", core_wr_be, ram_wr_be);
			check_bit("ram_wr_req", core_wr_req, ram_wr_req);
			check_bit("core_wr_ack", ram_wr_ack, core_wr_ack);
			check_bit("ioctl_wait", 1'b0, ioctl_wait);
		end
		@(negedge clk_1x);
		core_wr_req = 1'b0;
		ram_wr_ack  = 1'b0;
	endtask

	task automatic run_ram_download(input dl_index_t idx);
		dl_addr_t   base;
		dl_addr_t   addr;
		host_half_t lo;
		host_half_t hi;
		logic       is_exe;
		int         delay;
		int         k;
		int         c;
		is_exe = (idx == DL_IDX_EXE);
		base   = is_exe ? EXE_BASE : BIOS_BASE;
		@(negedge clk_1x);
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		// Core keeps requesting and must stay off the port
		core_wr_addr = dl_addr_t'($urandom);
		core_wr_data = $urandom;
		core_wr_be   = '0;
		core_wr_req  = 1'b1;
		@(negedge clk_1x);
		check_bit("ram_wr_req", 1'b0, ram_wr_req);
		check_be("ram_wr_be", '1, ram_wr_be);
		for (k = 0; k < DL_WORDS; k++) begin
			addr       = dl_addr_t'($urandom);
			addr[1:0]  = 2'b00;
			lo         = host_half_t'($urandom);
			hi         = host_half_t'($urandom);
			ioctl_addr = addr;
			ioctl_dout = lo;
			ioctl_wr   = 1'b1;
			@(negedge clk_1x);
			check_bit("ram_wr_req", 1'b0, ram_wr_req);
			check_bit("ioctl_wait", 1'b0, ioctl_wait);
			ioctl_addr = addr | dl_addr_t'(2);
			ioctl_dout = hi;
			@(negedge clk_1x);
			ioctl_wr = 1'b0;
			check_bit("ram_wr_req", 1'b1, ram_wr_req);
			check_bit("ioctl_wait", 1'b1, ioctl_wait);
			check_addr("ram_wr_addr", addr + base, ram_wr_addr);
			check_word("ram_wr_data", {hi, lo}, ram_wr_data);
			check_be("ram_wr_be", '1, ram_wr_be);
			// RAM answers late, host stays held
			delay = $urandom_range(0, 5);
			for (c = 0; c < delay; c++) begin
				@(negedge clk_1x);
				check_bit("ram_wr_req", 1'b0, ram_wr_req);
				check_bit("ioctl_wait", 1'b1, ioctl_wait);
			end
			ram_wr_ack = 1'b1;
			#1;
			// Acknowledge belongs to the loader, not the core
			check_bit("core_wr_ack", 1'b0, core_wr_ack);
			@(negedge clk_1x);
			ram_wr_ack = 1'b0;
			check_bit("ioctl_wait", 1'b0, ioctl_wait);
			check_bit("ram_wr_req", 1'b0, ram_wr_req);
		end
		ioctl_download = 1'b0;
		core_wr_req    = 1'b0;
		// Program load strobe on the second edge only
		for (c = 1; c <= 3; c++) begin
			@(negedge clk_1x);
			check_bit("exe_load", is_exe && (c == 2), exe_load);
			check_bit("ioctl_wait", 1'b0, ioctl_wait);
			check_bit("ram_wr_req", 1'b0, ram_wr_req);
		end
		ioctl_addr  = '0;
		ioctl_index = '0;
	endtask

	// Storage mount on the disc slot, checked one edge later
	task automatic mount_disc_image(input img_size_t size);
		@(negedge clk_1x);
		img_mounted            = '0;
		img_mounted[SLOT_DISC] = 1'b1;
		img_size               = size;
		if (size != '0) begin
			m_disc_present      = 1'b1;
			m_disc_size         = size[DISC_SIZE_W-1:0];
			m_disc_from_storage = 1'b1;
		end else begin
			m_disc_present = 1'b0;
		end
		@(negedge clk_1x);
		img_mounted = '0;
		img_size    = '0;
		check_bit("disc_present", m_disc_present, disc_present);
		check_disc_size("disc_size", m_disc_size, disc_size);
		check_bit("disc_from_storage", m_disc_from_storage, disc_from_storage);
	endtask

	task automatic run_disc_download();
		dl_index_t idx;
		dl_addr_t  addr;
		img_size_t mount_size;
		int        halves;
		int        k;
		// Storage image first, then an empty mount, so the download has work to do
		mount_size    = {$urandom, $urandom};
		mount_size[0] = 1'b1;
		mount_disc_image(mount_size);
		mount_disc_image('0);
		idx      = dl_index_t'($urandom);
		idx[5:0] = DL_IDX_DISC[5:0];
		addr     = dl_addr_t'($urandom_range(0, 1 << 20));
		addr[0]  = 1'b0;
		halves   = $urandom_range(3, DISC_OPS - 3);
		@(negedge clk_1x);
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		for (k = 0; k < halves; k++) begin
			@(negedge clk_1x);
			ioctl_addr = addr + dl_addr_t'(2 * k);
			ioctl_dout = host_half_t'($urandom);
			ioctl_wr   = 1'b1;
			@(negedge clk_1x);
			ioctl_wr = 1'b0;
			check_bit("ioctl_wait", 1'b0, ioctl_wait);
			check_bit("ram_wr_req", 1'b0, ram_wr_req);
		end
		// Last address stays on the bus until the size is taken
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_1x);
		m_disc_present      = 1'b1;
		m_disc_size         = disc_size_t'(ioctl_addr);
		m_disc_from_storage = 1'b0;
		check_bit("disc_present", m_disc_present, disc_present);
		check_disc_size("disc_size", m_disc_size, disc_size);
		check_bit("disc_from_storage", m_disc_from_storage, disc_from_storage);
		ioctl_addr  = '0;
		ioctl_index = '0;
	endtask

	task automatic drive_random_media_fb();
		if ($urandom_range(0, 3) == 0) begin
			img_mounted = $urandom_range(0, (1 << MOUNT_SLOTS) - 1);
		end else begin
			img_mounted = '0;
		end
		if ($urandom_range(0, 2) == 0) begin
			img_size = '0;
		end else begin
			img_size = {$urandom, $urandom};
		end
		if ($urandom_range(0, 3) == 0) opt_card_load = ~opt_card_load;
		if ($urandom_range(0, 3) == 0) opt_card_save = ~opt_card_save;
		if ($urandom_range(0, 3) == 0) opt_autosave = ~opt_autosave;
		if ($urandom_range(0, 3) == 0) osd_open = ~osd_open;
		opt_full_view    = $urandom_range(0, 1);
		opt_color24      = $urandom_range(0, 1);
		display_width    = fb_dim_t'($urandom);
		display_height   = fb_dim_t'($urandom);
		display_offset_x = $urandom_range(0, 1023);
		display_offset_y = $urandom_range(0, 511);
	endtask

	// Expected state one edge after the inputs just driven
	task automatic predict_media_fb();
		logic img_nonzero;
		logic menu_save;
		img_nonzero = (img_size != '0);
		menu_save   = osd_open & opt_autosave;
		if (img_mounted[SLOT_DISC]) begin
			if (img_nonzero) begin
				m_disc_present      = 1'b1;
				m_disc_size         = img_size[DISC_SIZE_W-1:0];
				m_disc_from_storage = 1'b1;
			end else begin
				m_disc_present = 1'b0;
			end
		end
		if (img_mounted[SLOT_CARD1]) m_card1_mounted = img_nonzero;
		if (img_mounted[SLOT_CARD2]) m_card2_mounted = img_nonzero;
		e_card1_load = (img_mounted[SLOT_CARD1] && img_nonzero) ||
			(opt_card_load && !m_card_load_q);
		e_card2_load = (img_mounted[SLOT_CARD2] && img_nonzero) ||
			(opt_card_load && !m_card_load_q);
		e_card_save  = (opt_card_save && !m_card_save_q) || (menu_save && !m_autosave_q);
		m_card_load_q = opt_card_load;
		m_card_save_q = opt_card_save;
		m_autosave_q  = menu_save;
		if (opt_full_view) begin
			e_fb_base   = FB_BASE_ADDR;
			e_fb_width  = FB_FULL_WIDTH;
			e_fb_height = FB_FULL_HEIGHT;
		end else begin
			e_fb_base   = FB_BASE_ADDR + fb_addr_t'(display_offset_y) * FB_STRIDE
				+ fb_addr_t'(display_offset_x) * FB_BYTES_PER_PIXEL;
			e_fb_width  = display_width;
			e_fb_height = display_height;
		end
		e_fb_format = opt_color24 ? FB_FMT_RGB24 : FB_FMT_RGB16;
	endtask

	task automatic check_media_fb();
		check_bit("disc_present", m_disc_present, disc_present);
		check_disc_size("disc_size", m_disc_size, disc_size);
		check_bit("disc_from_storage", m_disc_from_storage, disc_from_storage);
		check_bit("card1_mounted", m_card1_mounted, card1_mounted);
		check_bit("card2_mounted", m_card2_mounted, card2_mounted);
		check_bit("card1_load", e_card1_load, card1_load);
		check_bit("card2_load", e_card2_load, card2_load);
		check_bit("card_save", e_card_save, card_save);
		check_fb_addr("fb_base", e_fb_base, fb_base);
		check_dim("fb_width", e_fb_width, fb_width);
		check_dim("fb_height", e_fb_height, fb_height);
		check_format("fb_format", e_fb_format, fb_format);
	endtask

	task automatic run_media_fb_random();
		int i;
		for (i = 0; i < RANDOM_OPS; i++) begin
			@(negedge clk_1x);
			if (i > 0) check_media_fb();
			drive_random_media_fb();
			predict_media_fb();
		end
		@(negedge clk_1x);
		check_media_fb();
	endtask

	// ====================================================================
	// Test sequence and watchdog
	// ====================================================================
	initial begin
		seed_value = $urandom(32'hb223);
		init_inputs();
		wait (arst_n === 1'b1);
		@(negedge clk_1x);
		check_reset_state();
		run_core_passthrough();
		run_ram_download(DL_IDX_BIOS);
		run_ram_download(DL_IDX_EXE);
		run_ram_download(DL_IDX_EXE);
		run_ram_download(DL_IDX_BIOS);
		run_disc_download();
		run_media_fb_random();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within the watchdog limit");
		abort_run();
	end

endmodule

`default_nettype wire

//--- src.f
src/loader_pkg.sv
src/fb_pkg.sv
src/ram_loader.sv
src/media_tracker.sv
src/fb_setup.sv
src/psx_shell_top.sv
tests/tb_clk_gen.sv
tests/tb_psx_shell.sv

//--- Bender.yml
package:
  name: psx_shell

sources:
  - src/loader_pkg.sv
  - src/fb_pkg.sv
  - src/ram_loader.sv
  - src/media_tracker.sv
  - src/fb_setup.sv
  - src/psx_shell_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_psx_shell.sv
